// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_conv
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: sim clean

# Pass only when the exact pass line shows up in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/conv_ctrl.sv ====
module conv_ctrl import conv_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              ready_i,
    output logic              busy_o,
    output logic              conv_start_o,
    output logic              pool_start_o,
    input  mem_wr_t           conv_wr_i,
    input  mem_wr_t           pool_wr_i,
    input  mem_rd_t           pool_rd_i,
    output logic              cwr_o,
    output logic [ADDR_W-1:0] caddr_wr_o,
    output logic [DATA_W-1:0] cdata_wr_o,
    output logic              crd_o,
    output logic [ADDR_W-1:0] caddr_rd_o,
    output logic [2:0]        csel_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CONV,
        ST_POOL
    } state_t;

    state_t state_q;
    logic   start;
    logic   conv_done;
    logic   pool_done;

    // Pass ends are taken from the registered write port
    assign start     = (state_q == ST_IDLE) && ready_i;
    assign conv_done = (state_q == ST_CONV) && cwr_o && (caddr_wr_o == {ADDR_W{1'b1}});
    assign pool_done = (state_q == ST_POOL) && cwr_o
                       && (caddr_wr_o == ADDR_W'((1 << (2 * POOL_BITS)) - 1));

    // --------------------------------------------------
    // Pass sequencing
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q      <= ST_IDLE;
            busy_o       <= 1'b0;
            conv_start_o <= 1'b0;
            pool_start_o <= 1'b0;
        end else begin
            conv_start_o <= start;
            pool_start_o <= conv_done;
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_CONV;
                        busy_o  <= 1'b1;
                    end
                end
                ST_CONV: begin
                    if (conv_done) begin
                        state_q <= ST_POOL;
                    end
                end
                default: begin
                    if (pool_done) begin
                        state_q <= ST_IDLE;
                        busy_o  <= 1'b0;
                    end
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Memory side ports
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cwr_o  <= 1'b0;
            crd_o  <= 1'b0;
            csel_o <= SEL_NONE;
        end else begin
            case (state_q)
                ST_CONV: begin
                    cwr_o  <= conv_wr_i.valid;
                    crd_o  <= 1'b0;
                    csel_o <= SEL_LAYER0;
                end
                ST_POOL: begin
                    cwr_o  <= pool_wr_i.valid;
                    crd_o  <= pool_rd_i.valid;
                    csel_o <= pool_wr_i.valid ? SEL_LAYER1 : SEL_LAYER0;
                end
                default: begin
                    cwr_o  <= 1'b0;
                    crd_o  <= 1'b0;
                    csel_o <= SEL_NONE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_POOL) begin
            caddr_wr_o <= pool_wr_i.addr;
            cdata_wr_o <= pool_wr_i.data;
        end else begin
            caddr_wr_o <= conv_wr_i.addr;
            cdata_wr_o <= conv_wr_i.data;
        end
        caddr_rd_o <= pool_rd_i.addr;
    end

    // Pool reads and writes must interleave, never collide
    assert property (@(posedge clk) disable iff (reset) !(cwr_o && crd_o));
    assert property (@(posedge clk) disable iff (reset) (csel_o == SEL_LAYER1) |-> cwr_o);

endmodule

// ==== source/conv_pkg.sv ====
package conv_pkg;

    // --------------------------------------------------
    // Image geometry and fixed point
    // --------------------------------------------------
    localparam int IMG_BITS  = 6;
    localparam int IMG_SIZE  = 64;
    localparam int POOL_BITS = 5;
    localparam int ADDR_W    = 12;
    localparam int DATA_W    = 20;
    localparam int FRAC_W    = 16;
    localparam int ACC_W     = 40;
    localparam int TAPS      = 9;

    // Weights in row-major order, top-left first
    localparam logic signed [DATA_W-1:0] KERNEL [TAPS] = '{
        20'h0A89E, 20'h092D5, 20'h06D43,
        20'h01004, 20'hF8F71, 20'hF6E54,
        20'hFA6D7, 20'hFC834, 20'hFAC19
    };
    localparam logic signed [DATA_W-1:0] BIAS = 20'h01310;

    // Memory select codes on csel
    localparam logic [2:0] SEL_NONE   = 3'b000;
    localparam logic [2:0] SEL_LAYER0 = 3'b001;
    localparam logic [2:0] SEL_LAYER1 = 3'b011;

    // Testbench stimulus and run limits
    localparam logic [31:0] LFSR_SEED       = 32'h20bb_61ad;
    localparam int          NUM_ROWS        = 4;
    localparam int          TIMEOUT_PER_ROW = 50000;

    // --------------------------------------------------
    // Structs
    // --------------------------------------------------
    // Bit pattern doubles as the memory address
    typedef struct packed {
        logic [IMG_BITS-1:0] y;
        logic [IMG_BITS-1:0] x;
    } pix_t;

    typedef struct packed {
        logic       valid;
        logic       pad;
        logic [3:0] idx;
        logic       last;
        pix_t       pix;
    } tap_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } mem_wr_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } mem_rd_t;

endpackage

// ==== source/conv_top.sv ====
module conv_top import conv_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              ready_i,
    output logic              busy_o,
    output logic [ADDR_W-1:0] iaddr_o,
    input  logic [DATA_W-1:0] idata_i,
    output logic              cwr_o,
    output logic [ADDR_W-1:0] caddr_wr_o,
    output logic [DATA_W-1:0] cdata_wr_o,
    output logic              crd_o,
    output logic [ADDR_W-1:0] caddr_rd_o,
    input  logic [DATA_W-1:0] cdata_rd_i,
    output logic [2:0]        csel_o
);

    logic    conv_start;
    logic    pool_start;
    tap_t    tap;
    mem_wr_t conv_wr;
    mem_wr_t pool_wr;
    mem_rd_t pool_rd;

    conv_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .ready_i      (ready_i),
        .busy_o       (busy_o),
        .conv_start_o (conv_start),
        .pool_start_o (pool_start),
        .conv_wr_i    (conv_wr),
        .pool_wr_i    (pool_wr),
        .pool_rd_i    (pool_rd),
        .cwr_o        (cwr_o),
        .caddr_wr_o   (caddr_wr_o),
        .cdata_wr_o   (cdata_wr_o),
        .crd_o        (crd_o),
        .caddr_rd_o   (caddr_rd_o),
        .csel_o       (csel_o)
    );

    // Convolution pass
    window_addr_gen u_addr (
        .clk          (clk),
        .reset        (reset),
        .conv_start_i (conv_start),
        .iaddr_o      (iaddr_o),
        .tap_o        (tap)
    );

    mac_unit u_mac (
        .clk     (clk),
        .reset   (reset),
        .tap_i   (tap),
        .idata_i (idata_i),
        .wr_o    (conv_wr)
    );

    // Pooling pass
    pool_max u_pool (
        .clk          (clk),
        .reset        (reset),
        .pool_start_i (pool_start),
        .cdata_rd_i   (cdata_rd_i),
        .rd_o         (pool_rd),
        .wr_o         (pool_wr)
    );

endmodule

// ==== source/mac_unit.sv ====
module mac_unit import conv_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  tap_t              tap_i,
    input  logic [DATA_W-1:0] idata_i,
    output mem_wr_t           wr_o
);

    logic signed [DATA_W-1:0] weight;
    logic signed [DATA_W-1:0] pixel;
    logic signed [ACC_W-1:0]  prod_d;
    logic signed [ACC_W-1:0]  prod_q;
    logic signed [ACC_W-1:0]  bias_acc;
    logic signed [ACC_W-1:0]  acc_q;
    logic                     s1_valid_q;
    logic                     s1_first_q;
    logic                     s1_last_q;
    pix_t                     s1_pix_q;
    logic                     acc_last_q;
    pix_t                     acc_pix_q;
    logic [DATA_W-1:0]        result;
    logic                     wr_valid_q;
    logic [ADDR_W-1:0]        wr_addr_q;
    logic [DATA_W-1:0]        wr_data_q;

    assign bias_acc = {{(ACC_W - DATA_W - FRAC_W){BIAS[DATA_W-1]}}, BIAS, {FRAC_W{1'b0}}};

    // --------------------------------------------------
    // Stage 1 multiply
    // --------------------------------------------------
    always_comb begin
        weight = (tap_i.idx < 4'(TAPS)) ? KERNEL[tap_i.idx] : '0;
        // Zero padding outside the image
        pixel  = tap_i.pad ? '0 : signed'(idata_i);
        prod_d = pixel * weight;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid_q <= 1'b0;
            s1_first_q <= 1'b0;
            s1_last_q  <= 1'b0;
            acc_last_q <= 1'b0;
            wr_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= tap_i.valid;
            s1_first_q <= (tap_i.idx == 4'd0);
            s1_last_q  <= tap_i.valid && tap_i.last;
            acc_last_q <= s1_valid_q && s1_last_q;
            wr_valid_q <= acc_last_q;
        end
    end

    // --------------------------------------------------
    // Stage 2 accumulate and result
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        prod_q   <= prod_d;
        s1_pix_q <= tap_i.pix;
        if (s1_valid_q) begin
            acc_q     <= s1_first_q ? bias_acc + prod_q : acc_q + prod_q;
            acc_pix_q <= s1_pix_q;
        end
        wr_addr_q <= acc_pix_q;
        wr_data_q <= result;
    end

    // ReLU, then round at fraction bit 15
    always_comb begin
        if (acc_q[ACC_W-1]) begin
            result = '0;
        end else begin
            result = acc_q[FRAC_W+DATA_W-1:FRAC_W] + {{(DATA_W - 1){1'b0}}, acc_q[FRAC_W-1]};
        end
    end

    assign wr_o = '{valid: wr_valid_q, addr: wr_addr_q, data: wr_data_q};

    // Write leaves three cycles after the last tap came in
    assert property (@(posedge clk) disable iff (reset)
        wr_o.valid |-> $past(tap_i.valid && tap_i.last, 3));

endmodule

// ==== source/pool_max.sv ====
module pool_max import conv_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              pool_start_i,
    input  logic [DATA_W-1:0] cdata_rd_i,
    output mem_rd_t           rd_o,
    output mem_wr_t           wr_o
);

    logic                 active_q;
    logic [2:0]           phase_q;
    logic [POOL_BITS-1:0] by_q;
    logic [POOL_BITS-1:0] bx_q;
    logic [DATA_W-1:0]    max_q;
    logic                 blk_done;
    logic                 last_blk;
    pix_t                 rd_pix;

    // Phases 0-3 read, 1-4 compare, 5 writes
    assign blk_done = (phase_q == 3'd5);
    assign last_blk = &{by_q, bx_q};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_q <= 1'b0;
            phase_q  <= '0;
            by_q     <= '0;
            bx_q     <= '0;
        end else if (pool_start_i) begin
            active_q <= 1'b1;
            phase_q  <= '0;
            by_q     <= '0;
            bx_q     <= '0;
        end else if (active_q) begin
            if (blk_done) begin
                phase_q      <= '0;
                {by_q, bx_q} <= {by_q, bx_q} + 1'b1;
                if (last_blk) begin
                    active_q <= 1'b0;
                end
            end else begin
                phase_q <= phase_q + 3'd1;
            end
        end
    end

    // Read data lags its request by one cycle
    always_ff @(posedge clk) begin
        if (phase_q == 3'd1) begin
            max_q <= cdata_rd_i;
        end else if (phase_q >= 3'd2 && phase_q <= 3'd4
                     && $signed(cdata_rd_i) > $signed(max_q)) begin
            max_q <= cdata_rd_i;
        end
    end

    // Order (2y,2x) (2y+1,2x) (2y,2x+1) (2y+1,2x+1)
    assign rd_pix = '{y: {by_q, phase_q[0]}, x: {bx_q, phase_q[1]}};

    assign rd_o = '{valid: active_q && (phase_q < 3'd4), addr: rd_pix};
    assign wr_o = '{valid: active_q && blk_done,
                    addr: {{(ADDR_W - 2 * POOL_BITS){1'b0}}, by_q, bx_q},
                    data: max_q};

endmodule

// ==== source/window_addr_gen.sv ====
module window_addr_gen import conv_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              conv_start_i,
    output logic [ADDR_W-1:0] iaddr_o,
    output tap_t              tap_o
);

    logic              active_q;
    pix_t              pix_q;
    logic [3:0]        tap_q;
    logic [1:0]        row;
    logic [1:0]        col;
    logic [IMG_BITS:0] ny;
    logic [IMG_BITS:0] nx;
    logic              last_tap;
    logic              last_pix;

    assign last_tap = (tap_q == 4'(TAPS - 1));
    assign last_pix = (pix_q.y == IMG_BITS'(IMG_SIZE - 1))
                      && (pix_q.x == IMG_BITS'(IMG_SIZE - 1));

    // --------------------------------------------------
    // Pixel and tap counters
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_q <= 1'b0;
            pix_q    <= '0;
            tap_q    <= '0;
        end else if (conv_start_i) begin
            active_q <= 1'b1;
            pix_q    <= '0;
            tap_q    <= '0;
        end else if (active_q) begin
            if (last_tap) begin
                tap_q <= '0;
                // Raster order, wraps back to 0 after the last pixel
                pix_q <= pix_q + 1'b1;
                if (last_pix) begin
                    active_q <= 1'b0;
                end
            end else begin
                tap_q <= tap_q + 4'd1;
            end
        end
    end

    // --------------------------------------------------
    // Neighbour coordinates
    // --------------------------------------------------
    // Row and column of the tap inside the 3x3 window
    always_comb begin
        if (tap_q < 4'd3) begin
            row = 2'd0;
        end else if (tap_q < 4'd6) begin
            row = 2'd1;
        end else begin
            row = 2'd2;
        end
        col = 2'(tap_q - 4'd3 * {2'b00, row});
    end

    // Extra top bit catches both -1 and IMG_SIZE
    always_comb begin
        ny = {1'b0, pix_q.y} + {{(IMG_BITS - 1){1'b0}}, row} - 1'b1;
        nx = {1'b0, pix_q.x} + {{(IMG_BITS - 1){1'b0}}, col} - 1'b1;
    end

    assign iaddr_o = {ny[IMG_BITS-1:0], nx[IMG_BITS-1:0]};

    always_comb begin
        tap_o.valid = active_q;
        tap_o.pad   = ny[IMG_BITS] | nx[IMG_BITS];
        tap_o.idx   = tap_q;
        tap_o.last  = last_tap;
        tap_o.pix   = pix_q;
    end

    // Centre tap is the output pixel itself
    assert property (@(posedge clk) disable iff (reset)
        (tap_o.valid && tap_o.idx == 4'd4) |-> !tap_o.pad);

endmodule

// ==== src.f ====
+incdir+test
source/conv_pkg.sv
source/conv_ctrl.sv
source/window_addr_gen.sv
source/mac_unit.sv
source/pool_max.sv
source/conv_top.sv
test/tb_conv.sv

// ==== test/conv_model.svh ====
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// --------------------------------------------------
// Random pixel source
// --------------------------------------------------
// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

// One step per bit taken
function automatic logic [DATA_W-1:0] random_pixel();
    logic [DATA_W-1:0] value;
    value = '0;
    for (int i = 0; i < DATA_W; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        value      = {value[DATA_W-2:0], lfsr_state[0]};
    end
    return value;
endfunction

// --------------------------------------------------
// Layer models
// --------------------------------------------------
// 3x3 window with zero padding, bias scaled up to the product format
function automatic logic [DATA_W-1:0] expected_conv(input int y, input int x);
    longint           sum;
    logic [ACC_W-1:0] acc;
    int               ny;
    int               nx;
    sum = longint'(BIAS) <<< FRAC_W;
    for (int ky = 0; ky < 3; ky++) begin
        for (int kx = 0; kx < 3; kx++) begin
            ny = y + ky - 1;
            nx = x + kx - 1;
            if (ny >= 0 && ny < IMG_SIZE && nx >= 0 && nx < IMG_SIZE) begin
                sum += longint'($signed(image_mem[ny * IMG_SIZE + nx]))
                       * longint'(KERNEL[ky * 3 + kx]);
            end
        end
    end
    acc = sum[ACC_W-1:0];
    // Negative sums clip to zero
    if (acc[ACC_W-1]) begin
        return '0;
    end
    return acc[FRAC_W+DATA_W-1:FRAC_W] + DATA_W'(acc[FRAC_W-1]);
endfunction

// Signed maximum of one 2x2 block of layer 0
function automatic logic [DATA_W-1:0] expected_pool(input int by, input int bx);
    logic signed [DATA_W-1:0] best;
    logic signed [DATA_W-1:0] cand;
    best = exp_l0[(2 * by) * IMG_SIZE + 2 * bx];
    for (int dy = 0; dy < 2; dy++) begin
        for (int dx = 0; dx < 2; dx++) begin
            cand = exp_l0[(2 * by + dy) * IMG_SIZE + 2 * bx + dx];
            if (cand > best) begin
                best = cand;
            end
        end
    end
    return best;
endfunction

task automatic build_expected();
    for (int y = 0; y < IMG_SIZE; y++) begin
        for (int x = 0; x < IMG_SIZE; x++) begin
            exp_l0[y * IMG_SIZE + x] = expected_conv(y, x);
        end
    end
    for (int by = 0; by < IMG_SIZE / 2; by++) begin
        for (int bx = 0; bx < IMG_SIZE / 2; bx++) begin
            exp_l1[by * (IMG_SIZE / 2) + bx] = expected_pool(by, bx);
        end
    end
endtask

`endif

// ==== test/tb_conv.sv ====
module tb_conv import conv_pkg::*; ();

    typedef enum logic [1:0] {
        PAT_ZERO,
        PAT_CONST,
        PAT_LFSR,
        PAT_LARGE
    } pattern_t;

    // One row per run of the whole layer
    typedef struct packed {
        pattern_t          pattern;
        logic [DATA_W-1:0] fill;
        logic              hold_ready;
        int                l0_writes;
        int                l1_writes;
    } row_t;

    row_t rows [NUM_ROWS] = '{
        '{PAT_ZERO,  20'h00000, 1'b0, 4096, 1024},
        '{PAT_CONST, 20'h0C000, 1'b1, 4096, 1024},
        '{PAT_LFSR,  20'h00000, 1'b0, 4096, 1024},
        '{PAT_LARGE, 20'h00000, 1'b0, 4096, 1024}
    };

    logic              clk = 1'b0;
    logic              reset;
    logic              ready_i;
    logic              busy_o;
    logic [ADDR_W-1:0] iaddr_o;
    logic [DATA_W-1:0] idata_i;
    logic              cwr_o;
    logic [ADDR_W-1:0] caddr_wr_o;
    logic [DATA_W-1:0] cdata_wr_o;
    logic              crd_o;
    logic [ADDR_W-1:0] caddr_rd_o;
    logic [DATA_W-1:0] cdata_rd_i;
    logic [2:0]        csel_o;

    logic [DATA_W-1:0] image_mem  [IMG_SIZE * IMG_SIZE];
    logic [DATA_W-1:0] layer0_mem [IMG_SIZE * IMG_SIZE];
    logic [DATA_W-1:0] layer1_mem [IMG_SIZE * IMG_SIZE / 4];
    logic [DATA_W-1:0] exp_l0     [IMG_SIZE * IMG_SIZE];
    logic [DATA_W-1:0] exp_l1     [IMG_SIZE * IMG_SIZE / 4];
    logic [31:0]       lfsr_state;
    int                l0_count;
    int                l1_count;
    int                rd_count;
    int                cycle_count = 0;

    `include "conv_model.svh"

    conv_top uut (
        .clk        (clk),
        .reset      (reset),
        .ready_i    (ready_i),
        .busy_o     (busy_o),
        .iaddr_o    (iaddr_o),
        .idata_i    (idata_i),
        .cwr_o      (cwr_o),
        .caddr_wr_o (caddr_wr_o),
        .cdata_wr_o (cdata_wr_o),
        .crd_o      (crd_o),
        .caddr_rd_o (caddr_rd_o),
        .cdata_rd_i (cdata_rd_i),
        .csel_o     (csel_o)
    );

    always #50 clk = ~clk;

    // Both memories answer in the same cycle
    assign idata_i    = image_mem[iaddr_o];
    assign cdata_rd_i = layer0_mem[caddr_rd_o];

    // --------------------------------------------------
    // Failure reporting and compares
    // --------------------------------------------------
    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("Failure: %s", what);
        abort_run();
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pixel(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input pix_t got, input pix_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_sel(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // --------------------------------------------------
    // Port monitor
    // --------------------------------------------------
    // Layer 0 writes arrive in raster order before layer 1 in block order
    task automatic record_write();
        if (!busy_o) begin
            report_failure("memory write while busy_o is low");
        end
        if (l0_count < IMG_SIZE * IMG_SIZE) begin
            check_sel("csel_o", csel_o, SEL_LAYER0);
            check_addr("caddr_wr_o", pix_t'(caddr_wr_o), pix_t'(ADDR_W'(l0_count)));
            check_pixel("cdata_wr_o", cdata_wr_o, exp_l0[l0_count]);
            l0_count++;
        end else if (l1_count < IMG_SIZE * IMG_SIZE / 4) begin
            check_sel("csel_o", csel_o, SEL_LAYER1);
            check_addr("caddr_wr_o", pix_t'(caddr_wr_o), pix_t'(ADDR_W'(l1_count)));
            check_pixel("cdata_wr_o", cdata_wr_o, exp_l1[l1_count]);
            l1_count++;
        end else begin
            report_failure("more memory writes than one run produces");
        end
        if (csel_o == SEL_LAYER0) begin
            layer0_mem[caddr_wr_o] = cdata_wr_o;
        end else begin
            layer1_mem[caddr_wr_o[2*POOL_BITS-1:0]] = cdata_wr_o;
        end
    endtask

    // Four reads per block in the order (2y,2x) (2y+1,2x) (2y,2x+1) (2y+1,2x+1)
    function automatic pix_t pool_read_addr(input int n);
        int   blk;
        int   quad;
        pix_t pix;
        blk   = n / 4;
        quad  = n % 4;
        pix.y = IMG_BITS'(2 * (blk / (IMG_SIZE / 2)) + quad % 2);
        pix.x = IMG_BITS'(2 * (blk % (IMG_SIZE / 2)) + quad / 2);
        return pix;
    endfunction

    task automatic check_read();
        if (l0_count != IMG_SIZE * IMG_SIZE || !busy_o) begin
            report_failure("layer-0 read outside the pooling pass");
        end
        check_sel("csel_o", csel_o, SEL_LAYER0);
        check_addr("caddr_rd_o", pix_t'(caddr_rd_o), pool_read_addr(rd_count));
        rd_count++;
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (cwr_o && crd_o) begin
                report_failure("cwr_o and crd_o high in the same cycle");
            end
            if (cwr_o) begin
                record_write();
            end
            if (crd_o) begin
                check_read();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= NUM_ROWS * TIMEOUT_PER_ROW) begin
            $display("Timeout after %0d cycles without the runs finishing", cycle_count);
            abort_run();
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    // Near full scale with the sign set by the parity of the whole address
    function automatic logic [DATA_W-1:0] large_pixel(input logic [ADDR_W-1:0] addr);
        if (^addr) begin
            return 20'h80000 | {8'h00, addr};
        end
        return 20'h7F000 | {8'h00, addr};
    endfunction

    task automatic fill_image(input row_t row);
        for (int a = 0; a < IMG_SIZE * IMG_SIZE; a++) begin
            case (row.pattern)
                PAT_ZERO:  image_mem[a] = '0;
                PAT_CONST: image_mem[a] = row.fill;
                PAT_LFSR:  image_mem[a] = random_pixel();
                default:   image_mem[a] = large_pixel(ADDR_W'(a));
            endcase
        end
    endtask

    task automatic run_row(input row_t row);
        fill_image(row);
        build_expected();
        l0_count = 0;
        l1_count = 0;
        rd_count = 0;
        @(posedge clk);
        #10;
        ready_i = 1'b1;
        @(posedge clk);
        #10;
        check_bit("busy_o", busy_o, 1'b1);
        if (row.hold_ready) begin
            // Ready stays high through the convolution pass
            while (l0_count < IMG_SIZE * IMG_SIZE) begin
                @(negedge clk);
            end
            @(posedge clk);
            #10;
        end
        ready_i = 1'b0;
        while (busy_o) begin
            @(negedge clk);
        end
        if (l0_count != row.l0_writes || l1_count != row.l1_writes
            || rd_count != 4 * row.l1_writes) begin
            report_failure($sformatf("run ended after %0d layer-0 writes, %0d layer-1 writes and %0d reads",
                                     l0_count, l1_count, rd_count));
        end
        repeat (4) begin
            @(negedge clk);
            check_bit("busy_o", busy_o, 1'b0);
            check_sel("csel_o", csel_o, SEL_NONE);
        end
    endtask

    initial begin
        reset      = 1'b1;
        ready_i    = 1'b0;
        lfsr_state = LFSR_SEED;
        for (int a = 0; a < IMG_SIZE * IMG_SIZE; a++) begin
            image_mem[a]  = '0;
            layer0_mem[a] = '0;
        end
        for (int a = 0; a < IMG_SIZE * IMG_SIZE / 4; a++) begin
            layer1_mem[a] = '0;
        end
        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;
        @(negedge clk);
        check_bit("busy_o", busy_o, 1'b0);
        check_bit("cwr_o", cwr_o, 1'b0);
        check_bit("crd_o", crd_o, 1'b0);
        check_sel("csel_o", csel_o, SEL_NONE);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        $display("all tests passed");
        $finish;
    end

endmodule
